// File: Makefile
VERILATOR ?= verilator
TOP := pipelineTb
RTL_TOP := riscPipeline
FILELIST := verilog.f
BUILD_DIR := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS := --binary --timing -Wno-fatal
PASS_TEXT := === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Instruction-level model of the supported RV32I subset
// Uses imem, refMem, expAddr, expData, errors and MODEL_STEPS of the including module

function automatic logic [31:0] regOp(input int f7, input int f3, input int rd, input int rs1,
	input int rs2);
	return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] immOp(input int f3, input int rd, input int rs1, input int imm);
	return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
endfunction

function automatic logic [31:0] loadWord(input int rd, input int rs1, input int off);
	return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
endfunction

function automatic logic [31:0] storeWord(input int rs2, input int rs1, input int off);
	return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2, input int off);
	return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] jump(input int rd, input int off);
	return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
endfunction

function automatic logic [31:0] upperImm(input int rd, input int imm20);
	return {imm20[19:0], rd[4:0], 7'b0110111};
endfunction

function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
	input logic [31:0] a, input logic [31:0] b);
	case (f3)
		3'b000: return alt ? a - b : a + b;
		3'b001: return a << b[4:0];
		3'b010: return {31'b0, $signed(a) < $signed(b)};
		3'b011: return {31'b0, a < b};
		3'b100: return a ^ b;
		3'b101: begin
			if (alt) begin
				return $signed(a) >>> b[4:0];
			end
			return a >> b[4:0];
		end
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

// Runs imem from reset and records every store in program order
function automatic void runReference();
	logic [31:0] x [`REG_COUNT];
	logic [31:0] pc;
	logic [31:0] nextPc;
	logic [31:0] instr;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] addr;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immJ;
	logic [4:0] rd;
	logic [2:0] f3;
	logic taken;
	int step;
	foreach (x[i]) begin
		x[i] = '0;
	end
	expAddr.delete();
	expData.delete();
	pc = `RESET_PC;
	for (step = 0; step < MODEL_STEPS; step++) begin
		instr = imem[pc[9:2]];
		rd = instr[11:7];
		f3 = instr[14:12];
		a = x[instr[19:15]];
		b = x[instr[24:20]];
		immI = {{20{instr[31]}}, instr[31:20]};
		immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		nextPc = pc + 4;
		case (instr[6:0])
			7'b0110011: x[rd] = aluRef(f3, instr[30], a, b);
			7'b0010011: x[rd] = aluRef(f3, instr[30] && f3 == 3'b101, a, immI);
			7'b0000011: begin
				// Data region is 256-byte aligned
				addr = a + immI;
				x[rd] = refMem[addr[7:2]];
			end
			7'b0100011: begin
				addr = a + immS;
				refMem[addr[7:2]] = b;
				expAddr.push_back(addr);
				expData.push_back(b);
			end
			7'b1100011: begin
				case (f3)
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					default: taken = ($signed(a) >= $signed(b));
				endcase
				if (taken) begin
					nextPc = pc + immB;
				end
			end
			7'b1101111: begin
				// Jump to itself ends every program
				if (immJ == '0) begin
					return;
				end
				x[rd] = pc + 4;
				nextPc = pc + immJ;
			end
			7'b0110111: x[rd] = {instr[31:12], 12'b0};
			default: ;
		endcase
		x[0] = '0;
		pc = nextPc;
	end
	errors++;
	$display("Reference model never reached the closing jump loop");
endfunction

`endif

// File: bench/pipelineTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module pipelineTb;

	localparam logic [31:0] SEED = 32'h0fa9_9d20;
	localparam int RANDOM_LEN = 200;
	localparam int IMEM_WORDS = 256;
	localparam int DATA_WORDS = 64;
	localparam logic [31:0] DATA_BASE = 32'h0000_0400;
	localparam int MODEL_STEPS = 1000;
	localparam int DRAIN_CYCLES = 20;

	logic clk;
	logic reset;
	logic [31:0] iAddr;
	logic [31:0] iData;
	logic [31:0] dAddr;
	logic [31:0] dWriteData;
	logic dWriteEn;
	logic [31:0] dReadData;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DATA_WORDS];
	logic [31:0] refMem [DATA_WORDS];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	int progLen;
	int storeSlot;
	int storeIdx;
	int checks;
	int errors;
	logic running;
	logic watchReset;
	logic timedOut;

	`include "isaModel.svh"

	riscPipeline u_riscPipeline (
		.clk(clk),
		.reset(reset),
		.iAddr(iAddr),
		.iData(iData),
		.dAddr(dAddr),
		.dWriteData(dWriteData),
		.dWriteEn(dWriteEn),
		.dReadData(dReadData)
	);

	always #4 clk = ~clk;

	assign iData = imem[iAddr[9:2]];
	assign dReadData = dmem[dAddr[7:2]];

	always @(posedge clk) begin
		if (dWriteEn === 1'b1) begin
			dmem[dAddr[7:2]] <= dWriteData;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR %s: got 0x%08h, expected 0x%08h at %0t", name, got, expected, $time);
		end
	endtask

	// Stores against the model's sequence
	always @(negedge clk) begin
		if (watchReset) begin
			checkValue("iAddr", iAddr, `RESET_PC);
			checkValue("dWriteEn", {31'b0, dWriteEn}, 32'd0);
		end
		if (running && dWriteEn === 1'b1) begin
			if (storeIdx < expAddr.size()) begin
				checkValue("dAddr", dAddr, expAddr[storeIdx]);
				checkValue("dWriteData", dWriteData, expData[storeIdx]);
			end else begin
				errors++;
				$display("Unexpected store to 0x%08h after all %0d expected stores", dAddr,
					expAddr.size());
			end
			storeIdx++;
		end
	end

	function automatic logic [31:0] dataFill(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	task automatic fillMemories();
		foreach (imem[i]) begin
			imem[i] = `NOP_INSTR;
		end
		foreach (dmem[i]) begin
			dmem[i] = dataFill(DATA_BASE + 4 * i);
			refMem[i] = dmem[i];
		end
	endtask

	task automatic emit(input logic [31:0] word);
		imem[progLen] = word;
		progLen++;
	endtask

	task automatic emitStore(input int rs);
		emit(storeWord(rs, 1, (storeSlot % DATA_WORDS) * 4));
		storeSlot++;
	endtask

	task automatic loadDirected();
		int f3;
		int cond;
		int p;
		emit(immOp(0, 1, 0, DATA_BASE));
		emit(upperImm(4, 32'h87654));
		emit(immOp(0, 4, 4, 32'h329));
		// Dependent chain through x3 with each result stored at once
		emit(upperImm(3, 32'h12345));
		emitStore(3);
		for (f3 = 0; f3 < 8; f3++) begin
			emit(regOp(0, f3, 3, 3, 4));
			emitStore(3);
			if (f3 == 0 || f3 == 5) begin
				emit(regOp(32, f3, 3, 3, 4));
				emitStore(3);
			end
		end
		for (f3 = 0; f3 < 8; f3++) begin
			emit(immOp(f3, 3, 3, (f3 == 1 || f3 == 5) ? 7 : 12'h9a5));
			emitStore(3);
			if (f3 == 5) begin
				emit(immOp(f3, 3, 3, 32'h407));
				emitStore(3);
			end
		end
		// Load-use on rs1, on store data, on an immediate op
		emit(loadWord(5, 1, 0));
		emit(regOp(0, 0, 6, 5, 4));
		emitStore(6);
		emit(loadWord(7, 1, 4));
		emitStore(7);
		emit(loadWord(2, 1, 8));
		emit(immOp(4, 2, 2, 12'h0f0));
		emitStore(2);
		// x8 negative, x9 positive
		emit(immOp(0, 8, 0, 12'hff3));
		emit(immOp(0, 9, 0, 12'h055));
		emit(immOp(0, 10, 0, 12'h0aa));
		emit(immOp(0, 11, 0, 12'h0bb));
		for (cond = 0; cond < 4; cond++) begin
			for (p = 0; p < 3; p++) begin
				emit(branch((cond / 2) * 4 + cond % 2, (p == 2) ? 9 : 8, (p == 0) ? 8 : 9, 12));
				emitStore(10);
				emitStore(11);
				emitStore(9);
			end
		end
		emit(jump(13, 12));
		emitStore(10);
		emitStore(11);
		emitStore(13);
		emit(immOp(0, 0, 9, 5));
		emitStore(0);
		emit(upperImm(0, 32'hfffff));
		emitStore(0);
		emit(jump(0, 0));
	endtask

	task automatic loadRandom();
		int i;
		int kind;
		int f3;
		int cond;
		int rd;
		int rs1;
		int rs2;
		int k;
		int last;
		last = RANDOM_LEN - 1;
		emit(immOp(0, 1, 0, DATA_BASE));
		for (i = 1; i < last; i++) begin
			kind = $urandom % 16;
			f3 = $urandom % 8;
			cond = $urandom % 4;
			rs1 = $urandom % 16;
			rs2 = $urandom % 16;
			// x1 keeps the data base
			rd = $urandom % 16;
			if (rd == 1) begin
				rd = 0;
			end
			k = 1 + $urandom % 4;
			if (i + k > last) begin
				k = last - i;
			end
			if (kind < 4) begin
				emit(regOp((f3 == 0 || f3 == 5) ? 32 * ($urandom % 2) : 0, f3, rd, rs1, rs2));
			end else if (kind < 7) begin
				emit(immOp(f3, rd, rs1, (f3 == 1) ? $urandom % 32 :
					(f3 == 5) ? ($urandom % 2) * 32'h400 + $urandom % 32 : $urandom % 4096));
			end else if (kind < 9) begin
				emit(loadWord(rd, 1, ($urandom % DATA_WORDS) * 4));
			end else if (kind < 12) begin
				emit(storeWord(rs2, 1, ($urandom % DATA_WORDS) * 4));
			end else if (kind < 14) begin
				emit(branch((cond / 2) * 4 + cond % 2, rs1, rs2, 4 * k));
			end else if (kind == 14) begin
				emit(jump(rd, 4 * k));
			end else begin
				emit(upperImm(rd, $urandom));
			end
		end
		emit(jump(0, 0));
	endtask

	task automatic reportAndFinish(input bit timeoutSeen);
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeoutSeen);
		if (errors == 0 && !timeoutSeen) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	task automatic runProgram(input string name, input bit useRandom, output logic hitLimit);
		int cycles;
		int limit;
		hitLimit = 1'b0;
		#1 reset = 1'b1;
		running = 1'b0;
		@(posedge clk);
		#1 watchReset = 1'b1;
		progLen = 0;
		storeSlot = 0;
		fillMemories();
		if (useRandom) begin
			loadRandom();
		end else begin
			loadDirected();
		end
		runReference();
		storeIdx = 0;
		$display("Running %s program: %0d instructions, %0d stores expected", name, progLen,
			expAddr.size());
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		running = 1'b1;
		limit = 4 * progLen + 50;
		cycles = 0;
		@(posedge clk);
		#1 watchReset = 1'b0;
		while (storeIdx < expAddr.size() && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (storeIdx < expAddr.size()) begin
			$display("Timeout in %s program: %0d of %0d stores seen after %0d cycles", name,
				storeIdx, expAddr.size(), cycles);
			hitLimit = 1'b1;
		end else begin
			// Catch stores from instructions that should have been skipped
			repeat (DRAIN_CYCLES) @(posedge clk);
		end
		running = 1'b0;
	endtask

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		reset = 1'b1;
		running = 1'b0;
		watchReset = 1'b0;
		timedOut = 1'b0;
		checks = 0;
		errors = 0;
		storeIdx = 0;
		progLen = 0;
		storeSlot = 0;
		fillMemories();
		runProgram("directed", 1'b0, timedOut);
		if (!timedOut) begin
			runProgram("random", 1'b1, timedOut);
		end
		reportAndFinish(timedOut);
	end

endmodule

`default_nettype wire

// File: common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath and address width
`define XLEN 32

// Architectural integer registers
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

// File: common/hazardIf.sv
`timescale 1ns/1ps
`default_nettype none

interface hazardIf import isaPkg::*, pipePkg::*; ();

	regIdxT idRs1;
	regIdxT idRs2;
	regIdxT exRs1;
	regIdxT exRs2;
	regIdxT exRd;
	logic exMemRead;
	regIdxT memRd;
	logic memRegWrite;
	regIdxT wbRd;
	logic wbRegWrite;

	logic stall;
	fwdSelT fwdA;
	fwdSelT fwdB;

	modport hazard (
		input idRs1, idRs2, exRs1, exRs2, exRd, exMemRead,
		input memRd, memRegWrite, wbRd, wbRegWrite,
		output stall, fwdA, fwdB
	);

	modport pipe (
		output idRs1, idRs2, exRs1, exRs2, exRd, exMemRead,
		output memRd, memRegWrite, wbRd, wbRegWrite,
		input stall, fwdA, fwdB
	);

endinterface

`default_nettype wire

// File: common/isaPkg.sv
`default_nettype none

package isaPkg;

	// Major opcodes handled by the core
	typedef enum logic [6:0] {
		OP = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD = 7'b0000011,
		STORE = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL = 7'b1101111,
		LUI = 7'b0110111
	} opcodeT;

	typedef enum logic [2:0] {
		BEQ = 3'b000,
		BNE = 3'b001,
		BLT = 3'b100,
		BGE = 3'b101
	} branchCondT;

	typedef logic [4:0] regIdxT;
	typedef logic [2:0] funct3T;
	typedef logic [6:0] funct7T;

	// funct3 of register and immediate ALU ops
	localparam funct3T F3_ADD_SUB = 3'b000;
	localparam funct3T F3_SLL = 3'b001;
	localparam funct3T F3_SLT = 3'b010;
	localparam funct3T F3_SLTU = 3'b011;
	localparam funct3T F3_XOR = 3'b100;
	localparam funct3T F3_SRL_SRA = 3'b101;
	localparam funct3T F3_OR = 3'b110;
	localparam funct3T F3_AND = 3'b111;

	// lw and sw share this width code
	localparam funct3T F3_WORD = 3'b010;

	// Selects sub and sra
	localparam funct7T F7_ALT = 7'b0100000;

endpackage

`default_nettype wire

// File: common/pipePkg.sv
`default_nettype none

`include "cpu_params.svh"

package pipePkg;
	import isaPkg::*;

	typedef enum logic [3:0] {
		ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASSB
	} aluOpT;

	// Operand source for EX
	typedef enum logic [1:0] {
		FWD_REG, FWD_MEM, FWD_WB
	} fwdSelT;

	typedef struct packed {
		aluOpT aluOp;
		logic aluSrcImm;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isBranch;
		branchCondT branchCond;
		logic isJump;
		logic linkToReg;
	} ctrlT;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] pc;
		regIdxT rs1;
		regIdxT rs2;
		regIdxT rd;
		logic [`XLEN-1:0] rs1Val;
		logic [`XLEN-1:0] rs2Val;
		logic [`XLEN-1:0] imm;
		ctrlT ctrl;
	} idExT;

	typedef struct packed {
		logic valid;
		regIdxT rd;
		logic [`XLEN-1:0] aluResult;
		logic [`XLEN-1:0] storeData;
		logic [`XLEN-1:0] linkValue;
		ctrlT ctrl;
	} exMemT;

	typedef struct packed {
		logic valid;
		regIdxT rd;
		logic [`XLEN-1:0] wbValue;
		logic regWrite;
	} memWbT;

endpackage

`default_nettype wire

// File: decode/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module instrDecoder import isaPkg::*, pipePkg::*; (
	input wire [31:0] instr,
	output regIdxT rs1,
	output regIdxT rs2,
	output regIdxT rd,
	output ctrlT ctrl,
	output logic [`XLEN-1:0] imm
);

	opcodeT opcode;
	funct3T funct3;
	funct7T funct7;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;
	logic [`XLEN-1:0] immJ;
	logic [`XLEN-1:0] immU;

	function automatic aluOpT aluFromFunct(input funct3T f3, input logic alt);
		case (f3)
			F3_ADD_SUB: return alt ? SUB : ADD;
			F3_SLL: return SLL;
			F3_SLT: return SLT;
			F3_SLTU: return SLTU;
			F3_XOR: return XOR;
			F3_SRL_SRA: return alt ? SRA : SRL;
			F3_OR: return OR;
			F3_AND: return AND;
			default: return ADD;
		endcase
	endfunction

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
	assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21],
		1'b0};
	assign immU = {instr[31:12], 12'b0};

	always_comb begin
		rs1 = instr[19:15];
		rs2 = instr[24:20];
		rd = instr[11:7];
		imm = '0;
		ctrl = '0;
		case (opcode)
			OP: begin
				if (funct7 == '0 || funct7 == F7_ALT) begin
					ctrl.regWrite = 1'b1;
					ctrl.aluOp = aluFromFunct(funct3, funct7 == F7_ALT);
				end
			end
			OP_IMM: begin
				rs2 = '0;
				imm = immI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
				// Upper bits are immediate except for the right shifts
				ctrl.aluOp = aluFromFunct(funct3, funct3 == F3_SRL_SRA && funct7 == F7_ALT);
			end
			LOAD: begin
				rs2 = '0;
				imm = immI;
				if (funct3 == F3_WORD) begin
					ctrl.aluSrcImm = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.memRead = 1'b1;
				end
			end
			STORE: begin
				rd = '0;
				imm = immS;
				if (funct3 == F3_WORD) begin
					ctrl.aluSrcImm = 1'b1;
					ctrl.memWrite = 1'b1;
				end
			end
			BRANCH: begin
				rd = '0;
				imm = immB;
				if (funct3 inside {BEQ, BNE, BLT, BGE}) begin
					ctrl.isBranch = 1'b1;
					ctrl.branchCond = branchCondT'(funct3);
				end
			end
			JAL: begin
				rs1 = '0;
				rs2 = '0;
				imm = immJ;
				ctrl.isJump = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.linkToReg = 1'b1;
			end
			LUI: begin
				rs1 = '0;
				rs2 = '0;
				imm = immU;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = PASSB;
				ctrl.regWrite = 1'b1;
			end
			default: begin
				rs1 = '0;
				rs2 = '0;
				rd = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: decode/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module regFile import isaPkg::*; (
	input wire clk,
	input wire reset,
	input wire regIdxT readAddrA,
	input wire regIdxT readAddrB,
	output logic [`XLEN-1:0] readDataA,
	output logic [`XLEN-1:0] readDataB,
	input wire regIdxT writeAddr,
	input wire [`XLEN-1:0] writeData,
	input wire writeEn
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Write-through so WB and ID can overlap
	assign readDataA = (readAddrA == '0) ? '0 :
		(writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		(writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module alu import pipePkg::*; (
	input wire aluOpT op,
	input wire [`XLEN-1:0] a,
	input wire [`XLEN-1:0] b,
	output logic [`XLEN-1:0] result,
	output logic equal,
	output logic lessSigned
);

	localparam int SHAMT_W = $clog2(`XLEN);

	logic [SHAMT_W-1:0] shamt;
	logic lessUnsigned;

	assign shamt = b[SHAMT_W-1:0];

	// Compare flags also drive branch resolution
	assign equal = (a == b);
	assign lessSigned = ($signed(a) < $signed(b));
	assign lessUnsigned = (a < b);

	always_comb begin
		case (op)
			ADD: result = a + b;
			SUB: result = a - b;
			AND: result = a & b;
			OR: result = a | b;
			XOR: result = a ^ b;
			SLL: result = a << shamt;
			SRL: result = a >> shamt;
			SRA: result = $signed(a) >>> shamt;
			SLT: result = {{(`XLEN-1){1'b0}}, lessSigned};
			SLTU: result = {{(`XLEN-1){1'b0}}, lessUnsigned};
			PASSB: result = b;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import isaPkg::*, pipePkg::*; (
	hazardIf.hazard hz
);

	// Youngest producer wins
	function automatic fwdSelT pickSource(
		input regIdxT src,
		input regIdxT memRd,
		input logic memWr,
		input regIdxT wbRd,
		input logic wbWr
	);
		if (src == '0) begin
			return FWD_REG;
		end
		if (memWr && memRd == src) begin
			return FWD_MEM;
		end
		if (wbWr && wbRd == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	assign hz.fwdA = pickSource(hz.exRs1, hz.memRd, hz.memRegWrite, hz.wbRd, hz.wbRegWrite);
	assign hz.fwdB = pickSource(hz.exRs2, hz.memRd, hz.memRegWrite, hz.wbRd, hz.wbRegWrite);

	// Load data is not ready until MEM, so hold ID one cycle
	assign hz.stall = hz.exMemRead && hz.exRd != '0 &&
		(hz.exRd == hz.idRs1 || hz.exRd == hz.idRs2);

endmodule

`default_nettype wire

// File: logic/riscPipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module riscPipeline import isaPkg::*, pipePkg::*; (
	input wire clk,
	input wire reset,
	output logic [`XLEN-1:0] iAddr,
	input wire [`XLEN-1:0] iData,
	output logic [`XLEN-1:0] dAddr,
	output logic [`XLEN-1:0] dWriteData,
	output logic dWriteEn,
	input wire [`XLEN-1:0] dReadData
);

	hazardIf hz();

	logic [`XLEN-1:0] pc;
	logic [31:0] ifIdInstr;
	logic [`XLEN-1:0] ifIdPc;
	logic ifIdValid;
	idExT idEx;
	exMemT exMem;
	memWbT memWb;

	regIdxT idRs1;
	regIdxT idRs2;
	regIdxT idRd;
	ctrlT idCtrl;
	logic [`XLEN-1:0] idImm;
	logic [`XLEN-1:0] idRs1Val;
	logic [`XLEN-1:0] idRs2Val;

	logic [`XLEN-1:0] exOpA;
	logic [`XLEN-1:0] exOpB;
	logic [`XLEN-1:0] exAluB;
	logic [`XLEN-1:0] exAluResult;
	logic [`XLEN-1:0] exTarget;
	logic exEqual;
	logic exLess;
	logic branchTaken;
	logic takeXfer;

	logic [`XLEN-1:0] memResult;
	logic wbWriteEn;

	function automatic logic [`XLEN-1:0] fwdMux(
		input fwdSelT sel,
		input logic [`XLEN-1:0] regVal,
		input logic [`XLEN-1:0] memVal,
		input logic [`XLEN-1:0] wbVal
	);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// Fetch
	assign iAddr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (takeXfer) begin
			pc <= exTarget;
		end else if (!hz.stall) begin
			pc <= pc + `XLEN'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || takeXfer) begin
			ifIdInstr <= `NOP_INSTR;
			ifIdValid <= 1'b0;
		end else if (!hz.stall) begin
			ifIdInstr <= iData;
			ifIdPc <= pc;
			ifIdValid <= 1'b1;
		end
	end

	// Decode
	instrDecoder u_instrDecoder (
		.instr(ifIdInstr),
		.rs1(idRs1),
		.rs2(idRs2),
		.rd(idRd),
		.ctrl(idCtrl),
		.imm(idImm)
	);

	regFile u_regFile (
		.clk(clk),
		.reset(reset),
		.readAddrA(idRs1),
		.readAddrB(idRs2),
		.readDataA(idRs1Val),
		.readDataB(idRs2Val),
		.writeAddr(memWb.rd),
		.writeData(memWb.wbValue),
		.writeEn(wbWriteEn)
	);

	assign hz.idRs1 = idRs1;
	assign hz.idRs2 = idRs2;
	assign hz.exRs1 = idEx.rs1;
	assign hz.exRs2 = idEx.rs2;
	assign hz.exRd = idEx.rd;
	assign hz.exMemRead = idEx.valid && idEx.ctrl.memRead;
	assign hz.memRd = exMem.rd;
	assign hz.memRegWrite = exMem.valid && exMem.ctrl.regWrite;
	assign hz.wbRd = memWb.rd;
	assign hz.wbRegWrite = wbWriteEn;

	hazardUnit u_hazardUnit (
		.hz(hz)
	);

	// Bubble on load-use or on a redirect from EX
	always_ff @(posedge clk) begin
		if (reset || hz.stall || takeXfer) begin
			idEx.valid <= 1'b0;
		end else begin
			idEx <= '{valid: ifIdValid, pc: ifIdPc, rs1: idRs1, rs2: idRs2, rd: idRd,
				rs1Val: idRs1Val, rs2Val: idRs2Val, imm: idImm, ctrl: idCtrl};
		end
	end

	// Execute
	assign exOpA = fwdMux(hz.fwdA, idEx.rs1Val, memResult, memWb.wbValue);
	assign exOpB = fwdMux(hz.fwdB, idEx.rs2Val, memResult, memWb.wbValue);
	assign exAluB = idEx.ctrl.aluSrcImm ? idEx.imm : exOpB;

	alu u_alu (
		.op(idEx.ctrl.aluOp),
		.a(exOpA),
		.b(exAluB),
		.result(exAluResult),
		.equal(exEqual),
		.lessSigned(exLess)
	);

	always_comb begin
		case (idEx.ctrl.branchCond)
			BEQ: branchTaken = exEqual;
			BNE: branchTaken = !exEqual;
			BLT: branchTaken = exLess;
			BGE: branchTaken = !exLess;
			default: branchTaken = 1'b0;
		endcase
	end

	assign takeXfer = idEx.valid && (idEx.ctrl.isJump || (idEx.ctrl.isBranch && branchTaken));
	assign exTarget = idEx.pc + idEx.imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			exMem.valid <= 1'b0;
		end else begin
			exMem <= '{valid: idEx.valid, rd: idEx.rd, aluResult: exAluResult,
				storeData: exOpB, linkValue: idEx.pc + `XLEN'd4, ctrl: idEx.ctrl};
		end
	end

	// Memory
	assign dAddr = exMem.aluResult;
	assign dWriteData = exMem.storeData;
	assign dWriteEn = exMem.valid && exMem.ctrl.memWrite;

	// Writeback value and MEM forward source
	assign memResult = exMem.ctrl.memRead ? dReadData :
		exMem.ctrl.linkToReg ? exMem.linkValue : exMem.aluResult;

	always_ff @(posedge clk) begin
		if (reset) begin
			memWb.valid <= 1'b0;
		end else begin
			memWb <= '{valid: exMem.valid, rd: exMem.rd, wbValue: memResult,
				regWrite: exMem.ctrl.regWrite};
		end
	end

	assign wbWriteEn = memWb.valid && memWb.regWrite;

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
+incdir+bench
common/isaPkg.sv
common/pipePkg.sv
common/hazardIf.sv
decode/instrDecoder.sv
decode/regFile.sv
logic/alu.sv
logic/hazardUnit.sv
logic/riscPipeline.sv
bench/pipelineTb.sv
